//--- Bender.yml
package:
  name: ppu_bg

sources:
  - ppu_pkg.sv
  - ppu_line_timer.sv
  - ppu_regs.sv
  - ppu_bg_fetch.sv
  - ppu_pixel_out.sv
  - ppu_top.sv
  - target: test
    files:
      - tb_vram_model.sv
      - tb_ppu.sv

//--- ppu_bg_fetch.sv
// background tile fetcher
// runs 8 dot fetch slots through mode 3, reads tile map and tile data from
// vram and shifts out one colour index per dot
`timescale 1ns/100ps
`default_nettype none

module ppu_bg_fetch (
	input  logic                 clk_reg,
	input  logic                 reset,
	input  ppu_pkg::lcdc_t       lcdc,
	input  ppu_pkg::line_pos_t   pos,
	input  ppu_pkg::scroll_t     scroll,
	output logic                 vram_rd,
	output ppu_pkg::vram_addr_t  vram_addr,
	input  ppu_pkg::byte_t       vram_data,
	output ppu_pkg::shade_t      bg_pix,
	output logic                 bg_shift
);

	// slot phases, two dots each
	typedef enum logic [1:0] {
		PH_MAP  = 2'd0,
		PH_LO   = 2'd1,
		PH_HI   = 2'd2,
		PH_LOAD = 2'd3
	} fetch_phase_e;

	fetch_phase_e        phase;
	logic                xfer;
	logic                line_init;
	logic                slot_end;

	ppu_pkg::line_t      bg_line;
	logic [4:0]          map_col;
	ppu_pkg::vram_addr_t map_addr;
	ppu_pkg::vram_addr_t data_addr;

	// fetched tile, then its two bit planes
	ppu_pkg::byte_t      tile_num;
	ppu_pkg::byte_t      data_lo;
	ppu_pkg::byte_t      data_hi;
	ppu_pkg::byte_t      shift_lo;
	ppu_pkg::byte_t      shift_hi;

	// mode 3 starts at dot 80, a multiple of 8, so the dot gives the phase
	assign phase     = fetch_phase_e'(pos.dot[2:1]);
	assign xfer      = (pos.mode == ppu_pkg::XFER);
	assign line_init = (pos.dot == ppu_pkg::OAM_DOTS - 9'd1);
	assign slot_end  = xfer && (pos.dot[2:0] == 3'd7);

	// ------------------------------------------------------------
	// addressing
	// background line inside the 256 line map
	assign bg_line = pos.ly + scroll.scy;

	// 32x32 map, row from the line, column from the slot counter
	assign map_addr = (lcdc.bg_map_sel ? ppu_pkg::MAP_BASE1 : ppu_pkg::MAP_BASE0) |
		ppu_pkg::vram_addr_t'({bg_line[7:3], map_col});

	// 16 bytes per tile, two per row
	// signed mode puts tiles 0..127 at 0x1000 and 128..255 at 0x0800
	assign data_addr = {~lcdc.tile_data_sel & ~tile_num[7], tile_num, bg_line[2:0], 1'b0};

	always_comb begin
		case (phase)
			PH_LO:   vram_addr = data_addr;
			// high plane sits right after the low plane
			PH_HI:   vram_addr = {data_addr[12:1], 1'b1};
			default: vram_addr = map_addr;
		endcase
	end

	// read strobe on the first dot of each read phase
	assign vram_rd = xfer && !pos.dot[0] && (phase != PH_LOAD);

	// ------------------------------------------------------------
	// map column
	always_ff @(posedge clk_reg) begin
		if (reset)
			map_col <= '0;
		else if (line_init)
			map_col <= scroll.scx[7:3];
		else if (slot_end)
			// wraps at 32 by width
			map_col <= map_col + 5'd1;
	end

	// vram data shows up on the second dot of the phase
	always_ff @(posedge clk_reg) begin
		if (xfer && pos.dot[0]) begin
			case (phase)
				PH_MAP:  tile_num <= vram_data;
				PH_LO:   data_lo  <= vram_data;
				PH_HI:   data_hi  <= vram_data;
				default: ;
			endcase
		end
	end

	// ------------------------------------------------------------
	// pixel shifters
	// the first slot of a line has no tile yet and shifts out zeros
	always_ff @(posedge clk_reg) begin
		if (line_init) begin
			shift_lo <= '0;
			shift_hi <= '0;
		end else if (slot_end) begin
			shift_lo <= data_lo;
			shift_hi <= data_hi;
		end else if (xfer) begin
			shift_lo <= {shift_lo[6:0], 1'b0};
			shift_hi <= {shift_hi[6:0], 1'b0};
		end
	end

	// msb first, high plane is bit 1 of the colour index
	assign bg_pix   = {shift_hi[7], shift_lo[7]};
	assign bg_shift = xfer;

endmodule

`default_nettype wire

//--- ppu_line_timer.sv
// line and frame timer
// counts 456 dots by 154 lines while the lcd is on, decodes the cpu mode
// and latches the scroll registers once per line
`timescale 1ns/100ps
`default_nettype none

module ppu_line_timer (
	input  logic               clk_reg,
	input  logic               reset,
	input  ppu_pkg::lcdc_t     lcdc,
	input  ppu_pkg::byte_t     scx,
	input  ppu_pkg::byte_t     scy,
	output ppu_pkg::line_pos_t pos,
	output ppu_pkg::scroll_t   scroll
);

	// raw counters, pos follows them one cycle later
	ppu_pkg::dot_t      dot_cnt;
	ppu_pkg::line_t     ly_cnt;
	ppu_pkg::dot_t      xfer_end;
	ppu_pkg::ppu_mode_e mode_next;

	// ------------------------------------------------------------
	// dot and line counters
	always_ff @(posedge clk_reg) begin
		if (reset) begin
			dot_cnt <= '0;
			ly_cnt  <= '0;
		end else if (!lcdc.on) begin
			// lcd off parks the beam at the top left
			dot_cnt <= '0;
			ly_cnt  <= '0;
		end else if (dot_cnt == ppu_pkg::LINE_DOTS - 9'd1) begin
			dot_cnt <= '0;
			if (ly_cnt == ppu_pkg::FRAME_LINES - 8'd1)
				ly_cnt <= '0;
			else
				ly_cnt <= ly_cnt + 8'd1;
		end else begin
			dot_cnt <= dot_cnt + 9'd1;
		end
	end

	// scroll latch, two dots before mode 3 so the fetcher sees a settled value
	always_ff @(posedge clk_reg) begin
		if (reset) begin
			scroll <= '0;
		end else if (lcdc.on && (dot_cnt == ppu_pkg::OAM_DOTS - 9'd2)) begin
			scroll.scx <= scx;
			scroll.scy <= scy;
		end
	end

	// ------------------------------------------------------------
	// mode decode
	// a nonzero fine scroll costs one more fetch slot
	assign xfer_end = ppu_pkg::OAM_DOTS + ppu_pkg::XFER_BASE +
		((scroll.scx[2:0] != 3'd0) ? ppu_pkg::FETCH_SLOT : 9'd0);

	always_comb begin
		if (!lcdc.on)
			mode_next = ppu_pkg::HBLANK;
		else if (ly_cnt >= ppu_pkg::VISIBLE_LINES)
			mode_next = ppu_pkg::VBLANK;
		else if (dot_cnt < ppu_pkg::OAM_DOTS)
			mode_next = ppu_pkg::OAM;
		else if (dot_cnt < xfer_end)
			mode_next = ppu_pkg::XFER;
		else
			mode_next = ppu_pkg::HBLANK;
	end

	// registered broadcast of the beam position
	always_ff @(posedge clk_reg) begin
		if (reset) begin
			pos <= '0;
		end else if (!lcdc.on) begin
			// dot 0, line 0, hblank
			pos <= '0;
		end else begin
			pos.dot  <= dot_cnt;
			pos.ly   <= ly_cnt;
			pos.mode <= mode_next;
		end
	end

endmodule

`default_nettype wire

//--- ppu_pixel_out.sv
// pixel output stage
// drops the fine scroll pixels, passes 160 pixels per line through BGP
// and registers them toward the lcd
`timescale 1ns/100ps
`default_nettype none

module ppu_pixel_out (
	input  logic               clk_reg,
	input  logic               reset,
	input  ppu_pkg::lcdc_t     lcdc,
	input  ppu_pkg::line_pos_t pos,
	input  ppu_pkg::scroll_t   scroll,
	input  ppu_pkg::byte_t     bgp,
	input  ppu_pkg::shade_t    bg_pix,
	input  logic               bg_shift,
	output ppu_pkg::lcd_pix_t  pix
);

	// pixels still to drop, max 8 + 7
	logic [3:0]      skip_cnt;
	// pixels sent on this line
	ppu_pkg::byte_t  pix_cnt;
	logic            valid_q;
	ppu_pkg::shade_t shade_q;
	ppu_pkg::shade_t shade_next;

	// ------------------------------------------------------------
	// BGP lookup, two bits per colour index
	always_comb begin
		case (bg_pix)
			2'd0:    shade_next = bgp[1:0];
			2'd1:    shade_next = bgp[3:2];
			2'd2:    shade_next = bgp[5:4];
			default: shade_next = bgp[7:6];
		endcase
		// background off shows shade 0
		if (!lcdc.bg_ena)
			shade_next = 2'd0;
	end

	// ------------------------------------------------------------
	// skip and pixel counters
	always_ff @(posedge clk_reg) begin
		if (reset) begin
			skip_cnt <= '0;
			// nothing to send until the first line starts
			pix_cnt  <= ppu_pkg::SCREEN_W;
			valid_q  <= 1'b0;
		end else begin
			valid_q <= 1'b0;
			if (pos.dot == ppu_pkg::OAM_DOTS - 9'd1) begin
				// empty first slot plus the fine scroll
				skip_cnt <= 4'd8 + {1'b0, scroll.scx[2:0]};
				pix_cnt  <= '0;
			end else if (bg_shift) begin
				if (skip_cnt != 4'd0) begin
					skip_cnt <= skip_cnt - 4'd1;
				end else if (pix_cnt != ppu_pkg::SCREEN_W) begin
					valid_q <= 1'b1;
					pix_cnt <= pix_cnt + 8'd1;
				end
			end
		end
	end

	// shade register, qualified by valid_q
	always_ff @(posedge clk_reg) begin
		if (bg_shift)
			shade_q <= shade_next;
	end

	assign pix.valid = valid_q;
	assign pix.shade = shade_q;

endmodule

`default_nettype wire

//--- ppu_pkg.sv
// picture processing unit, shared definitions
// line timing constants, vector types, the mode encoding and the bus structs
`default_nettype none

package ppu_pkg;

	// ------------------------------------------------------------
	// vector types
	typedef logic [7:0]  byte_t;
	typedef logic [7:0]  reg_addr_t;
	// dot within a line, max 455
	typedef logic [8:0]  dot_t;
	// line within a frame, max 153
	typedef logic [7:0]  line_t;
	typedef logic [12:0] vram_addr_t;
	// colour index or final shade
	typedef logic [1:0]  shade_t;

	// ------------------------------------------------------------
	// timing
	localparam dot_t  LINE_DOTS     = 9'd456;
	localparam line_t FRAME_LINES   = 8'd154;
	localparam line_t VISIBLE_LINES = 8'd144;
	// mode 2 length
	localparam dot_t  OAM_DOTS      = 9'd80;
	localparam byte_t SCREEN_W      = 8'd160;
	// shortest mode 3, one extra slot is added for fine scroll
	localparam dot_t  XFER_BASE     = 9'd176;
	localparam dot_t  FETCH_SLOT    = 9'd8;

	// register offsets within the 0xff00 page
	localparam reg_addr_t ADDR_LCDC = 8'h40;
	localparam reg_addr_t ADDR_STAT = 8'h41;
	localparam reg_addr_t ADDR_SCY  = 8'h42;
	localparam reg_addr_t ADDR_SCX  = 8'h43;
	localparam reg_addr_t ADDR_LY   = 8'h44;
	localparam reg_addr_t ADDR_LYC  = 8'h45;
	localparam reg_addr_t ADDR_BGP  = 8'h47;

	localparam byte_t BGP_RESET = 8'hfc;

	// the two 32x32 tile maps at 0x9800 and 0x9c00
	localparam vram_addr_t MAP_BASE0 = 13'h1800;
	localparam vram_addr_t MAP_BASE1 = 13'h1c00;

	// ------------------------------------------------------------
	// mode as seen by the cpu in STAT[1:0]
	typedef enum logic [1:0] {
		HBLANK = 2'd0,
		VBLANK = 2'd1,
		OAM    = 2'd2,
		XFER   = 2'd3
	} ppu_mode_e;

	// LCDC, bit 7 first
	// window and sprite bits are stored only
	typedef struct packed {
		logic on;
		logic win_map;
		logic win_ena;
		logic tile_data_sel;
		logic bg_map_sel;
		logic spr_size;
		logic spr_ena;
		logic bg_ena;
	} lcdc_t;

	// beam position broadcast by the line timer
	typedef struct packed {
		dot_t      dot;
		line_t     ly;
		ppu_mode_e mode;
	} line_pos_t;

	// scroll values, constant over a line
	typedef struct packed {
		byte_t scx;
		byte_t scy;
	} scroll_t;

	// single cycle cpu strobe
	typedef struct packed {
		logic      sel;
		logic      wr;
		reg_addr_t addr;
		byte_t     wdata;
	} cpu_bus_t;

	// pixel toward the lcd, no back-pressure
	typedef struct packed {
		logic   valid;
		shade_t shade;
	} lcd_pix_t;

endpackage

`default_nettype wire

//--- ppu_regs.sv
// cpu register file of the background ppu
// LCDC, STAT, SCY, SCX, LY, LYC and BGP with a combinational read mux,
// plus the STAT and vblank interrupt pulses
`timescale 1ns/100ps
`default_nettype none

module ppu_regs (
	input  logic               clk_reg,
	input  logic               reset,
	input  ppu_pkg::cpu_bus_t  bus,
	output ppu_pkg::byte_t     rdata,
	input  ppu_pkg::line_pos_t pos,
	output ppu_pkg::lcdc_t     lcdc,
	output ppu_pkg::byte_t     scx,
	output ppu_pkg::byte_t     scy,
	output ppu_pkg::byte_t     bgp,
	output logic               irq,
	output logic               vblank_irq
);

	// STAT enable bits 6..3, the rest of STAT is status
	logic [3:0]         stat_ena;
	ppu_pkg::byte_t     lyc;
	logic               lyc_match;
	logic               wr_en;
	ppu_pkg::ppu_mode_e mode_q;

	// interrupt sources
	logic line_start;
	logic oam_start;
	logic hblank_start;
	logic vblank_start;

	assign wr_en     = bus.sel && bus.wr;
	assign lyc_match = (pos.ly == lyc);

	// ------------------------------------------------------------
	// register writes
	always_ff @(posedge clk_reg) begin
		if (reset) begin
			// lcd starts off
			lcdc     <= '0;
			stat_ena <= '0;
			scy      <= '0;
			scx      <= '0;
			lyc      <= '0;
			bgp      <= ppu_pkg::BGP_RESET;
		end else if (wr_en) begin
			case (bus.addr)
				ppu_pkg::ADDR_LCDC: lcdc     <= bus.wdata;
				ppu_pkg::ADDR_STAT: stat_ena <= bus.wdata[6:3];
				ppu_pkg::ADDR_SCY:  scy      <= bus.wdata;
				ppu_pkg::ADDR_SCX:  scx      <= bus.wdata;
				ppu_pkg::ADDR_LYC:  lyc      <= bus.wdata;
				ppu_pkg::ADDR_BGP:  bgp      <= bus.wdata;
				// LY is read only, unmapped writes are dropped
				default: ;
			endcase
		end
	end

	// ------------------------------------------------------------
	// read mux, same cycle as addr
	always_comb begin
		case (bus.addr)
			ppu_pkg::ADDR_LCDC: rdata = lcdc;
			// bit 7 always reads high
			ppu_pkg::ADDR_STAT: rdata = {1'b1, stat_ena, lyc_match, pos.mode};
			ppu_pkg::ADDR_SCY:  rdata = scy;
			ppu_pkg::ADDR_SCX:  rdata = scx;
			ppu_pkg::ADDR_LY:   rdata = pos.ly;
			ppu_pkg::ADDR_LYC:  rdata = lyc;
			ppu_pkg::ADDR_BGP:  rdata = bgp;
			default:            rdata = 8'hff;
		endcase
	end

	// ------------------------------------------------------------
	// interrupts
	// previous mode, for edge detection
	always_ff @(posedge clk_reg) begin
		if (reset)
			mode_q <= ppu_pkg::HBLANK;
		else
			mode_q <= pos.mode;
	end

	// dot 0 of a running line, the parked beam shows hblank and is excluded
	assign line_start = (pos.dot == 9'd0) && (pos.mode != ppu_pkg::HBLANK);

	assign oam_start    = (pos.mode == ppu_pkg::OAM) && (mode_q != ppu_pkg::OAM);
	assign hblank_start = (pos.mode == ppu_pkg::HBLANK) && (mode_q == ppu_pkg::XFER);

	// last dot of the last visible line
	assign vblank_start = (pos.dot == ppu_pkg::LINE_DOTS - 9'd1) &&
		(pos.ly == ppu_pkg::VISIBLE_LINES - 8'd1);

	assign vblank_irq = vblank_start;

	// any enabled STAT source, each one is a single cycle event
	// lcd off also hides the xfer edge when the beam is parked mid line
	assign irq = lcdc.on && (
		(stat_ena[3] && lyc_match && line_start) ||
		(stat_ena[2] && oam_start) ||
		(stat_ena[1] && vblank_start) ||
		(stat_ena[0] && hblank_start));

endmodule

`default_nettype wire

//--- ppu_top.sv
// background picture processing unit, top level
// connects the line timer, register file, tile fetcher and pixel stage
// to the cpu bus, the external vram and the lcd
`timescale 1ns/100ps
`default_nettype none

module ppu_top (
	input  logic                clk_reg,
	input  logic                reset,
	// cpu register bus
	input  ppu_pkg::cpu_bus_t   bus,
	output ppu_pkg::byte_t      rdata,
	// external vram, data one cycle after the read strobe
	output logic                vram_rd,
	output ppu_pkg::vram_addr_t vram_addr,
	input  ppu_pkg::byte_t      vram_data,
	// lcd
	output ppu_pkg::lcd_pix_t   pix,
	output logic                lcd_on,
	output logic                irq,
	output logic                vblank_irq
);

	ppu_pkg::lcdc_t     lcdc;
	ppu_pkg::byte_t     scx;
	ppu_pkg::byte_t     scy;
	ppu_pkg::byte_t     bgp;
	ppu_pkg::line_pos_t pos;
	ppu_pkg::scroll_t   scroll;
	// colour index stream from the fetcher
	ppu_pkg::shade_t    bg_pix;
	logic               bg_shift;

	assign lcd_on = lcdc.on;

	// ------------------------------------------------------------
	ppu_line_timer u_line_timer (
		.clk_reg (clk_reg),
		.reset   (reset),
		.lcdc    (lcdc),
		.scx     (scx),
		.scy     (scy),
		.pos     (pos),
		.scroll  (scroll)
	);

	ppu_regs u_regs (
		.clk_reg    (clk_reg),
		.reset      (reset),
		.bus        (bus),
		.rdata      (rdata),
		.pos        (pos),
		.lcdc       (lcdc),
		.scx        (scx),
		.scy        (scy),
		.bgp        (bgp),
		.irq        (irq),
		.vblank_irq (vblank_irq)
	);

	ppu_bg_fetch u_bg_fetch (
		.clk_reg   (clk_reg),
		.reset     (reset),
		.lcdc      (lcdc),
		.pos       (pos),
		.scroll    (scroll),
		.vram_rd   (vram_rd),
		.vram_addr (vram_addr),
		.vram_data (vram_data),
		.bg_pix    (bg_pix),
		.bg_shift  (bg_shift)
	);

	ppu_pixel_out u_pixel_out (
		.clk_reg  (clk_reg),
		.reset    (reset),
		.lcdc     (lcdc),
		.pos      (pos),
		.scroll   (scroll),
		.bgp      (bgp),
		.bg_pix   (bg_pix),
		.bg_shift (bg_shift),
		.pix      (pix)
	);

endmodule

`default_nettype wire

//--- sim.f
ppu_pkg.sv
ppu_line_timer.sv
ppu_regs.sv
ppu_bg_fetch.sv
ppu_pixel_out.sv
ppu_top.sv
tb_vram_model.sv
tb_ppu.sv

//--- tb_ppu.sv
// testbench for the background ppu
// directed tests of the register file, mode timing, pixel stream and
// both interrupts, against a behavioural vram
`timescale 1ns/100ps
`default_nettype none

module tb_ppu;

	localparam int DOTS = int'(ppu_pkg::LINE_DOTS);
	localparam int FRAME_CYCLES = DOTS * int'(ppu_pkg::FRAME_LINES);
	localparam int PIX_PER_LINE = int'(ppu_pkg::SCREEN_W);
	localparam int FRAME_PIXELS = PIX_PER_LINE * int'(ppu_pkg::VISIBLE_LINES);
	// three reads per slot, at most 23 slots per visible line
	localparam int MAX_READS = 3 * 23 * int'(ppu_pkg::VISIBLE_LINES);
	// the tests take under six frames, slack covers register accesses
	localparam int WATCHDOG_NS = (6 * FRAME_CYCLES + 10000) * 10;

	logic                clk_reg;
	logic                reset;
	ppu_pkg::cpu_bus_t   bus;
	ppu_pkg::byte_t      rdata;
	logic                vram_rd;
	ppu_pkg::vram_addr_t vram_addr;
	ppu_pkg::byte_t      vram_data;
	ppu_pkg::lcd_pix_t   pix;
	logic                lcd_on;
	logic                irq;
	logic                vblank_irq;

	logic [31:0]         lcg_state;
	// shades of the current frame, in lcd order
	ppu_pkg::shade_t     shade_buf [0:FRAME_PIXELS-1];
	int                  pix_count;
	// vram read addresses of the current frame, in issue order
	ppu_pkg::vram_addr_t read_buf [0:MAX_READS-1];
	int                  read_count;

	ppu_top dut (
		.clk_reg    (clk_reg),
		.reset      (reset),
		.bus        (bus),
		.rdata      (rdata),
		.vram_rd    (vram_rd),
		.vram_addr  (vram_addr),
		.vram_data  (vram_data),
		.pix        (pix),
		.lcd_on     (lcd_on),
		.irq        (irq),
		.vblank_irq (vblank_irq)
	);

	tb_vram_model vram (
		.clk_reg (clk_reg),
		.rd      (vram_rd),
		.addr    (vram_addr),
		.data    (vram_data)
	);

	// 10 ns clock
	always #5 clk_reg = ~clk_reg;

	// ------------------------------------------------------------
	// error reporting and compares
	task automatic report_error(input string msg);
		$display("%s", msg);
		$display("Test failures found");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_byte(input string name, input ppu_pkg::byte_t got,
		input ppu_pkg::byte_t exp);
		if (got !== exp)
			report_error($sformatf("FAIL t=%0t %s got=0x%02h exp=0x%02h",
				$time, name, got, exp));
	endtask

	task automatic check_shade(input string name, input ppu_pkg::shade_t got,
		input ppu_pkg::shade_t exp);
		if (got !== exp)
			report_error($sformatf("FAIL t=%0t %s got=%0d exp=%0d", $time, name, got, exp));
	endtask

	task automatic check_mode(input string name, input ppu_pkg::ppu_mode_e got,
		input ppu_pkg::ppu_mode_e exp);
		if (got !== exp)
			report_error($sformatf("FAIL t=%0t %s got=%0d exp=%0d", $time, name, got, exp));
	endtask

	task automatic check_addr(input string name, input ppu_pkg::vram_addr_t got,
		input ppu_pkg::vram_addr_t exp);
		if (got !== exp)
			report_error($sformatf("FAIL t=%0t %s got=0x%04h exp=0x%04h",
				$time, name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			report_error($sformatf("FAIL t=%0t %s got=%0b exp=%0b", $time, name, got, exp));
	endtask

	// ------------------------------------------------------------
	// stimulus helpers
	function automatic ppu_pkg::byte_t lcg_byte();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16];
	endfunction

	// one cycle write strobe, then the bus goes idle
	task automatic write_reg(input ppu_pkg::reg_addr_t addr, input ppu_pkg::byte_t data);
		@(posedge clk_reg);
		#1;
		bus.sel   = 1'b1;
		bus.wr    = 1'b1;
		bus.addr  = addr;
		bus.wdata = data;
		@(posedge clk_reg);
		#1;
		bus.sel = 1'b0;
		bus.wr  = 1'b0;
	endtask

	// one cycle per call, read data sampled mid cycle
	task automatic read_reg(input ppu_pkg::reg_addr_t addr, output ppu_pkg::byte_t data);
		@(posedge clk_reg);
		#1;
		bus.sel  = 1'b1;
		bus.wr   = 1'b0;
		bus.addr = addr;
		@(negedge clk_reg);
		data = rdata;
	endtask

	// ------------------------------------------------------------
	// reference model
	function automatic ppu_pkg::ppu_mode_e expected_mode(input int dot,
		input ppu_pkg::byte_t scx);
		int xfer_len;
		xfer_len = int'(ppu_pkg::XFER_BASE) + ((scx[2:0] != 3'd0) ? 8 : 0);
		if (dot < int'(ppu_pkg::OAM_DOTS))
			return ppu_pkg::OAM;
		else if (dot < int'(ppu_pkg::OAM_DOTS) + xfer_len)
			return ppu_pkg::XFER;
		else
			return ppu_pkg::HBLANK;
	endfunction

	// map entry for background row by and tile column col
	function automatic int map_entry_addr(input int by, input int col,
		input ppu_pkg::lcdc_t cfg);
		return (cfg.bg_map_sel ? int'(ppu_pkg::MAP_BASE1) : int'(ppu_pkg::MAP_BASE0)) +
			(by / 8) * 32 + col % 32;
	endfunction

	// low plane of the tile row, the map byte is its low address byte xor 0x5a
	function automatic int tile_row_addr(input int map_addr, input int by,
		input ppu_pkg::lcdc_t cfg);
		int tile;
		int row_addr;
		tile = (map_addr % 256) ^ 90;
		if (cfg.tile_data_sel)
			row_addr = tile * 16;
		else if (tile >= 128)
			// signed tile number around 0x1000
			row_addr = 4096 + (tile - 256) * 16;
		else
			row_addr = 4096 + tile * 16;
		return row_addr + 2 * (by % 8);
	endfunction

	// one map read and two plane reads per 8 dot slot of mode 3
	function automatic int reads_per_line(input ppu_pkg::byte_t scx);
		return 3 * (int'(ppu_pkg::XFER_BASE) + ((scx[2:0] != 3'd0) ? 8 : 0)) / 8;
	endfunction

	// address of read n within a line
	function automatic ppu_pkg::vram_addr_t expected_read_addr(input int ly, input int n,
		input ppu_pkg::byte_t scx, input ppu_pkg::byte_t scy, input ppu_pkg::lcdc_t cfg);
		int by;
		int map_addr;
		by = (ly + int'(scy)) % 256;
		map_addr = map_entry_addr(by, int'(scx) / 8 + n / 3, cfg);
		if (n % 3 == 0)
			return ppu_pkg::vram_addr_t'(map_addr);
		return ppu_pkg::vram_addr_t'(tile_row_addr(map_addr, by, cfg) + n % 3 - 1);
	endfunction

	// shade of pixel x on line ly, from map and tile data in vram
	function automatic ppu_pkg::shade_t expected_shade(input int ly, input int x,
		input ppu_pkg::byte_t scx, input ppu_pkg::byte_t scy,
		input ppu_pkg::byte_t bgp, input ppu_pkg::lcdc_t cfg);
		int bx;
		int by;
		int row_addr;
		int lo;
		int hi;
		int bit_pos;
		int idx;
		bx = (x + int'(scx)) % 256;
		by = (ly + int'(scy)) % 256;
		row_addr = tile_row_addr(map_entry_addr(by, bx / 8, cfg), by, cfg);
		// data byte is its low address byte times 3
		lo = ((row_addr % 256) * 3) % 256;
		hi = (((row_addr + 1) % 256) * 3) % 256;
		bit_pos = 7 - bx % 8;
		idx = ((hi >> bit_pos) & 1) * 2 + ((lo >> bit_pos) & 1);
		if (!cfg.bg_ena)
			return 2'd0;
		return ppu_pkg::shade_t'((int'(bgp) >> (2 * idx)) & 3);
	endfunction

	// ------------------------------------------------------------
	// pixel and vram read monitor, restarts with the lcd and at each vblank
	always @(negedge clk_reg) begin
		if (reset || !lcd_on) begin
			pix_count  = 0;
			read_count = 0;
		end else begin
			if (pix.valid) begin
				if (pix_count >= FRAME_PIXELS)
					report_error("lcd received more pixels than a frame holds");
				shade_buf[pix_count] = pix.shade;
				pix_count = pix_count + 1;
			end
			if (vram_rd) begin
				if (read_count >= MAX_READS)
					report_error("vram saw more reads than a frame needs");
				read_buf[read_count] = vram_addr;
				read_count = read_count + 1;
			end
			if (vblank_irq) begin
				if (pix_count != FRAME_PIXELS)
					report_error($sformatf("frame ended with %0d pixels instead of %0d",
						pix_count, FRAME_PIXELS));
				pix_count  = 0;
				read_count = 0;
			end
		end
	end

	// ------------------------------------------------------------
	// directed tests
	task automatic test_reset_readback();
		ppu_pkg::byte_t     val;
		ppu_pkg::byte_t     wr_val;
		ppu_pkg::reg_addr_t addrs [4];
		int                 i;
		addrs[0] = ppu_pkg::ADDR_SCY;
		addrs[1] = ppu_pkg::ADDR_SCX;
		addrs[2] = ppu_pkg::ADDR_LYC;
		addrs[3] = ppu_pkg::ADDR_BGP;
		read_reg(ppu_pkg::ADDR_LCDC, val);
		check_byte("lcdc", val, 8'h00);
		read_reg(ppu_pkg::ADDR_BGP, val);
		check_byte("bgp", val, 8'hfc);
		read_reg(ppu_pkg::ADDR_LY, val);
		check_byte("ly", val, 8'h00);
		for (i = 0; i < 4; i++) begin
			wr_val = lcg_byte();
			write_reg(addrs[i], wr_val);
			read_reg(addrs[i], val);
			check_byte($sformatf("register 0x%02h", addrs[i]), val, wr_val);
		end
		// unmapped offset
		read_reg(8'h4a, val);
		check_byte("unmapped 0x4a", val, 8'hff);
	endtask

	task automatic test_modes();
		ppu_pkg::byte_t stat;
		ppu_pkg::byte_t ly;
		int             i;
		int             line;
		int             wait_cnt;
		int             rd_cycles;
		write_reg(ppu_pkg::ADDR_SCX, 8'h00);
		write_reg(ppu_pkg::ADDR_SCY, 8'h00);
		write_reg(ppu_pkg::ADDR_LYC, 8'h00);
		write_reg(ppu_pkg::ADDR_STAT, 8'h00);
		write_reg(ppu_pkg::ADDR_LCDC, 8'h91);
		check_bit("lcd_on", lcd_on, 1'b1);
		// first mode 2 after power up is dot 0 of line 0
		wait_cnt = 0;
		read_reg(ppu_pkg::ADDR_STAT, stat);
		while (stat[1:0] != 2'd2) begin
			wait_cnt++;
			if (wait_cnt > 1000)
				report_error("timed out waiting for mode 2 after the lcd was enabled");
			read_reg(ppu_pkg::ADDR_STAT, stat);
		end
		// lines 0 and 1, LYC matches only on line 0
		rd_cycles = 0;
		for (i = 0; i < 2 * DOTS; i++) begin
			if (i > 0)
				read_reg(ppu_pkg::ADDR_STAT, stat);
			line = i / DOTS;
			check_mode("stat.mode", ppu_pkg::ppu_mode_e'(stat[1:0]),
				expected_mode(i % DOTS, 8'h00));
			check_byte("stat bits 7 and 2", stat & 8'h84, (line == 0) ? 8'h84 : 8'h80);
			if (vram_rd && stat[1:0] != 2'd3)
				report_error("vram_rd was high outside mode 3");
			if (vram_rd)
				rd_cycles++;
		end
		if (rd_cycles == 0)
			report_error("no vram reads were seen during mode 3");
		// skip ahead to line 144
		wait_cnt = 0;
		read_reg(ppu_pkg::ADDR_LY, ly);
		while (ly != 8'd144) begin
			wait_cnt++;
			if (wait_cnt > FRAME_CYCLES)
				report_error("timed out waiting for LY to reach 144");
			read_reg(ppu_pkg::ADDR_LY, ly);
		end
		// rest of the vblank lines, LY sampled once per line
		for (i = 1; i < 10 * DOTS; i++) begin
			if (i % DOTS == 200) begin
				read_reg(ppu_pkg::ADDR_LY, ly);
				check_byte("ly in vblank", ly, 8'(144 + i / DOTS));
			end else begin
				read_reg(ppu_pkg::ADDR_STAT, stat);
				check_mode("stat.mode", ppu_pkg::ppu_mode_e'(stat[1:0]), ppu_pkg::VBLANK);
			end
			if (vram_rd)
				report_error("vram_rd was high during vblank");
		end
		// wrapped to line 0
		read_reg(ppu_pkg::ADDR_STAT, stat);
		check_mode("stat.mode", ppu_pkg::ppu_mode_e'(stat[1:0]), ppu_pkg::OAM);
		write_reg(ppu_pkg::ADDR_LCDC, 8'h00);
		check_bit("lcd_on", lcd_on, 1'b0);
		read_reg(ppu_pkg::ADDR_LY, ly);
		check_byte("ly with lcd off", ly, 8'h00);
		read_reg(ppu_pkg::ADDR_STAT, stat);
		check_mode("stat.mode", ppu_pkg::ppu_mode_e'(stat[1:0]), ppu_pkg::HBLANK);
	endtask

	// restart the frame with a new setup and check one line of pixels
	task automatic test_pixel_line(input ppu_pkg::byte_t lcdc_val, input ppu_pkg::byte_t scx,
		input ppu_pkg::byte_t scy, input ppu_pkg::byte_t bgp, input int line);
		ppu_pkg::lcdc_t cfg;
		int             x;
		int             l;
		int             n;
		int             rpl;
		int             wait_cnt;
		cfg = ppu_pkg::lcdc_t'(lcdc_val);
		rpl = reads_per_line(scx);
		write_reg(ppu_pkg::ADDR_LCDC, 8'h00);
		write_reg(ppu_pkg::ADDR_SCX, scx);
		write_reg(ppu_pkg::ADDR_SCY, scy);
		write_reg(ppu_pkg::ADDR_BGP, bgp);
		write_reg(ppu_pkg::ADDR_LCDC, lcdc_val);
		wait_cnt = 0;
		while (pix_count < (line + 1) * PIX_PER_LINE ||
			read_count < (line + 1) * rpl) begin
			@(posedge clk_reg);
			wait_cnt++;
			if (wait_cnt > (line + 2) * DOTS)
				report_error($sformatf("timed out waiting for the pixels of line %0d", line));
		end
		for (x = 0; x < PIX_PER_LINE; x++)
			check_shade($sformatf("pix.shade line %0d x %0d", line, x),
				shade_buf[line * PIX_PER_LINE + x],
				expected_shade(line, x, scx, scy, bgp, cfg));
		// fetch addresses of every line up to the checked one
		for (l = 0; l <= line; l++)
			for (n = 0; n < rpl; n++)
				check_addr($sformatf("vram_addr line %0d read %0d", l, n),
					read_buf[l * rpl + n], expected_read_addr(l, n, scx, scy, cfg));
	endtask

	task automatic test_interrupts();
		ppu_pkg::byte_t     val;
		ppu_pkg::ppu_mode_e mode;
		ppu_pkg::ppu_mode_e prev_mode;
		int                 i;
		int                 irq_cnt;
		int                 vb_cnt;
		write_reg(ppu_pkg::ADDR_LCDC, 8'h00);
		write_reg(ppu_pkg::ADDR_STAT, 8'h40);
		write_reg(ppu_pkg::ADDR_LYC, 8'd10);
		write_reg(ppu_pkg::ADDR_LCDC, 8'h91);
		// one frame with the LYC source
		irq_cnt = 0;
		vb_cnt  = 0;
		for (i = 0; i < FRAME_CYCLES; i++) begin
			read_reg(ppu_pkg::ADDR_LY, val);
			if (irq) begin
				check_byte("ly at lyc irq", val, 8'd10);
				irq_cnt++;
			end
			if (vblank_irq) begin
				check_byte("ly at vblank_irq", val, 8'd143);
				vb_cnt++;
			end
		end
		if (irq_cnt != 1)
			report_error($sformatf("expected one lyc irq per frame, saw %0d", irq_cnt));
		if (vb_cnt != 1)
			report_error($sformatf("expected one vblank_irq per frame, saw %0d", vb_cnt));
		// one frame with the hblank source only
		write_reg(ppu_pkg::ADDR_STAT, 8'h08);
		read_reg(ppu_pkg::ADDR_STAT, val);
		prev_mode = ppu_pkg::ppu_mode_e'(val[1:0]);
		irq_cnt = 0;
		vb_cnt  = 0;
		for (i = 0; i < FRAME_CYCLES; i++) begin
			read_reg(ppu_pkg::ADDR_STAT, val);
			mode = ppu_pkg::ppu_mode_e'(val[1:0]);
			if (irq) begin
				check_mode("stat.mode at hblank irq", mode, ppu_pkg::HBLANK);
				check_mode("stat.mode before hblank irq", prev_mode, ppu_pkg::XFER);
				irq_cnt++;
			end
			if (vblank_irq)
				vb_cnt++;
			prev_mode = mode;
		end
		if (irq_cnt != 144)
			report_error($sformatf("expected 144 hblank irqs per frame, saw %0d", irq_cnt));
		if (vb_cnt != 1)
			report_error($sformatf("expected one vblank_irq per frame, saw %0d", vb_cnt));
	endtask

	// ------------------------------------------------------------
	// main sequence
	initial begin
		clk_reg    = 1'b0;
		reset      = 1'b1;
		bus.sel    = 1'b0;
		bus.wr     = 1'b0;
		bus.addr   = '0;
		bus.wdata  = '0;
		pix_count  = 0;
		read_count = 0;
		lcg_state  = 32'd26519;
		repeat (4) @(posedge clk_reg);
		#1;
		reset = 1'b0;

		test_reset_readback();
		test_modes();
		// unsigned tile data, map 0
		test_pixel_line(8'h91, 8'h00, 8'h00, 8'he4, 0);
		// signed tile data
		test_pixel_line(8'h81, 8'h00, 8'h00, 8'he4, 37);
		// fine and coarse scroll on map 1
		test_pixel_line(8'h99, 8'h03, 8'h05, 8'h1b, 77);
		// background disabled
		test_pixel_line(8'h98, 8'h03, 8'h05, 8'h1b, 3);
		test_interrupts();

		$display("All tests passed!");
		$finish;
	end

	// watchdog
	initial begin
		#(WATCHDOG_NS);
		report_error("watchdog expired before the tests finished");
	end

endmodule

`default_nettype wire

//--- tb_vram_model.sv
// behavioural vram for the ppu testbench
// contents are a fixed function of the address, read data one cycle after rd
`timescale 1ns/100ps
`default_nettype none

module tb_vram_model (
	input  logic                clk_reg,
	input  logic                rd,
	input  ppu_pkg::vram_addr_t addr,
	output ppu_pkg::byte_t      data
);

	// ------------------------------------------------------------
	// memory contents
	// tile maps sit from 0x1800 up, everything below is tile data
	function automatic ppu_pkg::byte_t content(input ppu_pkg::vram_addr_t a);
		if (a >= ppu_pkg::MAP_BASE0)
			// map byte, tile number varies along the row
			return a[7:0] ^ 8'h5a;
		else
			// data byte, gives mixed bit planes
			return a[7:0] * 8'd3;
	endfunction

	// ------------------------------------------------------------
	// read port
	// no data before the first read
	initial data = '0;

	// one cycle of latency, data holds between reads
	always @(posedge clk_reg) begin
		if (rd)
			data <= content(addr);
	end

endmodule

`default_nettype wire
